/* src.f */
csr_pkg.sv
csr_access.sv
csr_trap_state.sv
csr_counters.sv
csr_unit.sv
tb_clkgen.sv
csr_properties.sv
tb_csr.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_csr
FILELIST  := src.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Regression passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb_csr.sv */
module tb_csr;
    timeunit 1ns;
    timeprecision 100ps;

    logic                 clk;
    logic                 rst_n;
    logic                 rd_en;
    logic                 wr_en;
    csr_pkg::csr_addr_t   addr;
    logic [31:0]          wr_data;
    logic [31:0]          rd_data;
    logic                 illegal_csr;
    logic                 trap_insert;
    logic                 trap_is_mret;
    logic [31:0]          trap_epc;
    logic [31:0]          trap_cause;
    logic [31:0]          trap_val;
    logic                 timer_irq;
    logic                 retire;
    csr_pkg::priv_mode_e  priv;
    logic [31:0]          mtvec;
    logic [31:0]          mepc;
    logic                 irq_request;
    integer               seed;
    logic [31:0]          rnd;

    tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

    csr_unit u_dut (.*);

    // stop at the first assertion failure
    always @(negedge clk) begin
        if (u_dut.u_props.fail_count != 0) begin
            $display("Regression failed");
            $fatal(1, "an assertion in csr_properties failed");
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // bus tasks, all driven on the falling edge
    ////////////////////////////////////////////////////////////////////////
    task automatic csr_write(input csr_pkg::csr_addr_t a, input logic [31:0] d);
        @(negedge clk);
        {rd_en, wr_en, trap_insert, retire} = 4'b0100;
        addr = a;
        wr_data = d;
    endtask

    task automatic csr_read(input csr_pkg::csr_addr_t a);
        @(negedge clk);
        {rd_en, wr_en, trap_insert, retire} = 4'b1000;
        addr = a;
    endtask

    task automatic idle_cycle(input logic ret);
        @(negedge clk);
        {rd_en, wr_en, trap_insert} = 3'b000;
        retire = ret;
    endtask

    task automatic trap(input logic mret, input logic [31:0] epc, input logic [31:0] cause);
        @(negedge clk);
        {rd_en, wr_en, retire} = 3'b000;
        trap_insert = 1'b1;
        trap_is_mret = mret;
        trap_epc = epc;
        trap_cause = cause;
        trap_val = ~epc;
    endtask

    task automatic timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("Regression failed");
        $fatal(1, "simulation stopped on timeout");
    endtask

    initial begin
        int n;
        csr_pkg::csr_addr_t rw_addrs[3];
        rw_addrs = '{csr_pkg::ADDR_MSCRATCH, csr_pkg::ADDR_MCAUSE, csr_pkg::ADDR_MTVAL};
        seed = 32'h2aa7f382;
        rd_en = 1'b1;
        wr_en = 1'b0;
        addr = csr_pkg::ADDR_MSTATUS;
        wr_data = '0;
        {trap_insert, trap_is_mret, timer_irq, retire} = 4'b0000;
        trap_epc = '0;
        trap_cause = '0;
        trap_val = '0;

        // mstatus is being read as reset goes away
        for (n = 0; n < 20 && rst_n !== 1'b1; n++) @(posedge clk);
        if (rst_n !== 1'b1) timeout("reset release");
        csr_read(csr_pkg::ADDR_MIMPID);

        for (int i = 0; i < 3; i++) begin
            rnd = $random(seed);
            csr_write(rw_addrs[i], rnd);
            csr_read(rw_addrs[i]);
        end
        rnd = $random(seed);
        csr_write(csr_pkg::ADDR_MTVEC, {rnd[31:2], 2'b01});
        csr_read(csr_pkg::ADDR_MTVEC);
        rnd = $random(seed);
        csr_write(csr_pkg::ADDR_MTVEC, {rnd[31:2], 2'b11});
        csr_read(csr_pkg::ADDR_MTVEC);

        ////////////////////////////////////////////////////////////////////
        // counters
        ////////////////////////////////////////////////////////////////////
        repeat (4) csr_read(csr_pkg::ADDR_CYCLE);
        csr_write(csr_pkg::ADDR_MCOUNTINHIBIT, 32'h1);
        repeat (4) csr_read(csr_pkg::ADDR_CYCLE);
        csr_write(csr_pkg::ADDR_MCOUNTINHIBIT, 32'h0);
        rnd = $random(seed);
        csr_write(csr_pkg::ADDR_MINSTRET, rnd);
        repeat (8) begin
            rnd = $random(seed);
            idle_cycle(rnd[0]);
        end
        csr_read(csr_pkg::ADDR_MINSTRET);

        ////////////////////////////////////////////////////////////////////
        // trap, mret and user mode
        ////////////////////////////////////////////////////////////////////
        csr_write(csr_pkg::ADDR_MIE, 32'h80);
        csr_write(csr_pkg::ADDR_MSTATUS, 32'h8);
        rnd = $random(seed);
        trap(1'b0, rnd, 32'h0000_000b);
        csr_read(csr_pkg::ADDR_MCAUSE);
        csr_read(csr_pkg::ADDR_MSTATUS);
        // MPP back to user before returning
        csr_write(csr_pkg::ADDR_MSTATUS, 32'h0);
        trap(1'b1, '0, '0);
        for (n = 0; n < 10 && priv != csr_pkg::PRIV_U; n++) idle_cycle(1'b0);
        if (priv != csr_pkg::PRIV_U) timeout("user mode after mret");

        timer_irq = 1'b1;
        csr_read(csr_pkg::ADDR_MSCRATCH);
        rnd = $random(seed);
        csr_write(csr_pkg::ADDR_MSCRATCH, rnd);
        csr_read(csr_pkg::ADDR_CYCLE);
        trap(1'b0, 32'h100, 32'h8000_0007);
        csr_read(csr_pkg::ADDR_MSCRATCH);
        csr_write(csr_pkg::ADDR_MSTATUS, 32'h8);
        for (n = 0; n < 10 && irq_request !== 1'b1; n++) idle_cycle(1'b0);
        if (irq_request !== 1'b1) timeout("irq_request");
        timer_irq = 1'b0;
        repeat (3) idle_cycle(1'b0);

        if (u_dut.u_props.fail_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "checks failed during the run");
        end
    end
endmodule

/* csr_properties.sv */
module csr_properties (
    input logic                        clk,
    input logic                        rst_n,
    input logic                        rd_en,
    input logic                        wr_en,
    input csr_pkg::csr_addr_t          addr,
    input logic [csr_pkg::XLEN-1:0]    wr_data,
    input logic [csr_pkg::XLEN-1:0]    rd_data,
    input logic                        illegal_csr,
    input logic                        trap_insert,
    input logic                        trap_is_mret,
    input logic [csr_pkg::XLEN-1:0]    trap_epc,
    input logic [csr_pkg::XLEN-1:0]    trap_cause,
    input logic                        timer_irq,
    input logic                        retire,
    input csr_pkg::priv_mode_e         priv,
    input logic [csr_pkg::XLEN-1:0]    mtvec,
    input logic [csr_pkg::XLEN-1:0]    mepc,
    input logic                        irq_request
);
    timeunit 1ns;
    timeprecision 100ps;

    int                  fail_count = 0;
    logic                wr_m;
    logic                mie_s;
    logic                mpie_s;
    csr_pkg::priv_mode_e mpp_s;
    logic                mti_s;
    logic                cy_inh;
    logic                ir_inh;
    logic                instret_known;
    logic [31:0]         instret_s;
    logic [31:0]         mscratch_s;

    // expected mtvec after legalization
    function automatic logic [31:0] mtvec_legal(input logic [31:0] d);
        if (d[1:0] == 2'b01) begin
            return {d[31:6], 4'b0000, 2'b01};
        end
        return {d[31:2], 2'b00};
    endfunction

    assign wr_m = wr_en && priv == csr_pkg::PRIV_M;

    ////////////////////////////////////////////////////////////////////////
    // reference state
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_s         <= 1'b1;
            mpie_s        <= 1'b1;
            mpp_s         <= csr_pkg::PRIV_U;
            mti_s         <= 1'b0;
            cy_inh        <= 1'b0;
            ir_inh        <= 1'b0;
            instret_known <= 1'b0;
            instret_s     <= '0;
            mscratch_s    <= '0;
        end else begin
            if (wr_m && addr == csr_pkg::ADDR_MSTATUS) begin
                mie_s  <= wr_data[3];
                mpie_s <= wr_data[7];
                mpp_s  <= (wr_data[12:11] == 2'b11) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
            end
            if (wr_m && addr == csr_pkg::ADDR_MIE) begin
                mti_s <= wr_data[7];
            end
            if (wr_m && addr == csr_pkg::ADDR_MSCRATCH) begin
                mscratch_s <= wr_data;
            end
            if (wr_m && addr == csr_pkg::ADDR_MCOUNTINHIBIT) begin
                cy_inh <= wr_data[0];
                ir_inh <= wr_data[2];
            end
            // write beats the retire increment
            if (wr_m && addr == csr_pkg::ADDR_MINSTRET) begin
                instret_s     <= wr_data;
                instret_known <= 1'b1;
            end else if (retire && !ir_inh) begin
                instret_s <= instret_s + 1;
            end
            if (trap_insert && trap_is_mret) begin
                mie_s  <= mpie_s;
                mpie_s <= 1'b1;
                mpp_s  <= csr_pkg::PRIV_U;
            end else if (trap_insert) begin
                mpie_s <= mie_s;
                mie_s  <= 1'b0;
                mpp_s  <= priv;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////
    reset_state: assert property (@(posedge clk) rst_n && !$past(rst_n) |->
        priv == csr_pkg::PRIV_M && !irq_request)
        else begin
            fail_count++;
            $error("ERROR t=%0t priv got %0d expected 3, irq_request got %b expected 0",
                $time, priv, irq_request);
        end

    mimpid_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && addr == csr_pkg::ADDR_MIMPID && !illegal_csr |-> rd_data == 32'h1)
        else begin
            fail_count++;
            $error("ERROR t=%0t rd_data got %h expected 1", $time, rd_data);
        end

    mstatus_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && addr == csr_pkg::ADDR_MSTATUS && !illegal_csr |->
        rd_data[3] == mie_s && rd_data[7] == mpie_s && rd_data[12:11] == mpp_s)
        else begin
            fail_count++;
            $error("ERROR t=%0t mstatus got %h expected mie %b mpie %b mpp %0d",
                $time, rd_data, mie_s, mpie_s, mpp_s);
        end

    round_trip: assert property (@(posedge clk) disable iff (!rst_n)
        $past(wr_m && !trap_insert && (addr == csr_pkg::ADDR_MCAUSE ||
        addr == csr_pkg::ADDR_MTVAL)) && rd_en && addr == $past(addr) |->
        rd_data == $past(wr_data))
        else begin
            fail_count++;
            $error("ERROR t=%0t rd_data got %h expected %h",
                $time, rd_data, $past(wr_data));
        end

    mscratch_read: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && addr == csr_pkg::ADDR_MSCRATCH && !illegal_csr |-> rd_data == mscratch_s)
        else begin
            fail_count++;
            $error("ERROR t=%0t mscratch got %h expected %h",
                $time, rd_data, mscratch_s);
        end

    mtvec_legalize: assert property (@(posedge clk) disable iff (!rst_n)
        $past(wr_m && addr == csr_pkg::ADDR_MTVEC) && rd_en && addr == csr_pkg::ADDR_MTVEC |->
        rd_data == mtvec_legal($past(wr_data)) && mtvec == rd_data)
        else begin
            fail_count++;
            $error("ERROR t=%0t mtvec read got %h port got %h expected %h",
                $time, rd_data, mtvec, mtvec_legal($past(wr_data)));
        end

    cycle_step: assert property (@(posedge clk) disable iff (!rst_n)
        rd_en && addr == csr_pkg::ADDR_CYCLE &&
        $past(rd_en && !wr_en && addr == csr_pkg::ADDR_CYCLE) |->
        rd_data == $past(rd_data) + ($past(cy_inh) ? 0 : 1))
        else begin
            fail_count++;
            $error("ERROR t=%0t cycle got %h expected step from %h",
                $time, rd_data, $past(rd_data));
        end

    instret_count: assert property (@(posedge clk) disable iff (!rst_n)
        instret_known && rd_en && addr == csr_pkg::ADDR_MINSTRET && !illegal_csr |->
        rd_data == instret_s)
        else begin
            fail_count++;
            $error("ERROR t=%0t minstret got %h expected %h",
                $time, rd_data, instret_s);
        end

    trap_entry: assert property (@(posedge clk) disable iff (!rst_n)
        trap_insert && !trap_is_mret |=> mepc == $past(trap_epc) && priv == csr_pkg::PRIV_M)
        else begin
            fail_count++;
            $error("ERROR t=%0t mepc got %h expected %h, priv got %0d expected 3",
                $time, mepc, $past(trap_epc), priv);
        end

    trap_cause_read: assert property (@(posedge clk) disable iff (!rst_n)
        $past(trap_insert && !trap_is_mret) && rd_en && addr == csr_pkg::ADDR_MCAUSE |->
        rd_data == $past(trap_cause))
        else begin
            fail_count++;
            $error("ERROR t=%0t mcause got %h expected %h",
                $time, rd_data, $past(trap_cause));
        end

    mret_priv: assert property (@(posedge clk) disable iff (!rst_n)
        trap_insert && trap_is_mret |=> priv == $past(mpp_s))
        else begin
            fail_count++;
            $error("ERROR t=%0t priv got %0d expected %0d",
                $time, priv, $past(mpp_s));
        end

    user_denied: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_en || wr_en) && priv == csr_pkg::PRIV_U && addr == csr_pkg::ADDR_MSCRATCH |->
        illegal_csr)
        else begin
            fail_count++;
            $error("ERROR t=%0t illegal_csr got 0 expected 1", $time);
        end

    alias_allowed: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_en || wr_en) && addr == csr_pkg::ADDR_CYCLE |-> !illegal_csr)
        else begin
            fail_count++;
            $error("ERROR t=%0t illegal_csr got 1 expected 0", $time);
        end

    irq_gate: assert property (@(posedge clk) disable iff (!rst_n)
        irq_request == ($past(timer_irq) && mti_s && (priv != csr_pkg::PRIV_M || mie_s)))
        else begin
            fail_count++;
            $error("ERROR t=%0t irq_request got %b expected %b", $time, irq_request,
                $past(timer_irq) && mti_s && (priv != csr_pkg::PRIV_M || mie_s));
        end
endmodule

bind csr_unit csr_properties u_props (.*);

/* tb_clkgen.sv */
module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // two cycles of reset, released away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end
endmodule

/* csr_unit.sv */
module csr_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        rd_en,
    input  logic                        wr_en,
    input  csr_pkg::csr_addr_t          addr,
    input  logic [csr_pkg::XLEN-1:0]    wr_data,
    output logic [csr_pkg::XLEN-1:0]    rd_data,
    output logic                        illegal_csr,
    input  logic                        trap_insert,
    input  logic                        trap_is_mret,
    input  logic [csr_pkg::XLEN-1:0]    trap_epc,
    input  logic [csr_pkg::XLEN-1:0]    trap_cause,
    input  logic [csr_pkg::XLEN-1:0]    trap_val,
    input  logic                        timer_irq,
    input  logic                        retire,
    output csr_pkg::priv_mode_e         priv,
    output logic [csr_pkg::XLEN-1:0]    mtvec,
    output logic [csr_pkg::XLEN-1:0]    mepc,
    output logic                        irq_request
);

    csr_pkg::csr_sel_e              wr_sel;
    logic [csr_pkg::XLEN-1:0]       mstatus_val;
    logic [csr_pkg::XLEN-1:0]       mie_val;
    logic [csr_pkg::XLEN-1:0]       mip_val;
    logic [csr_pkg::XLEN-1:0]       mscratch;
    logic [csr_pkg::XLEN-1:0]       mcause;
    logic [csr_pkg::XLEN-1:0]       mtval;
    logic [csr_pkg::CNT_W-1:0]      mcycle;
    logic [csr_pkg::CNT_W-1:0]      minstret;
    logic [csr_pkg::XLEN-1:0]       mcountinhibit_val;

    csr_access u_access (
        .rd_en(rd_en), .wr_en(wr_en), .addr(addr), .priv(priv),
        .mstatus_val(mstatus_val), .mtvec(mtvec), .mie_val(mie_val),
        .mip_val(mip_val), .mscratch(mscratch), .mepc(mepc),
        .mcause(mcause), .mtval(mtval), .mcycle(mcycle),
        .minstret(minstret), .mcountinhibit_val(mcountinhibit_val),
        .rd_data(rd_data), .illegal_csr(illegal_csr), .wr_sel(wr_sel)
    );

    csr_trap_state u_trap_state (
        .clk(clk), .rst_n(rst_n), .wr_sel(wr_sel), .wr_data(wr_data),
        .trap_insert(trap_insert), .trap_is_mret(trap_is_mret),
        .trap_epc(trap_epc), .trap_cause(trap_cause), .trap_val(trap_val),
        .timer_irq(timer_irq), .priv(priv), .mstatus_val(mstatus_val),
        .mtvec(mtvec), .mie_val(mie_val), .mip_val(mip_val),
        .mscratch(mscratch), .mepc(mepc), .mcause(mcause), .mtval(mtval),
        .irq_request(irq_request)
    );

    csr_counters u_counters (
        .clk(clk), .rst_n(rst_n), .wr_sel(wr_sel), .wr_data(wr_data),
        .retire(retire), .mcycle(mcycle), .minstret(minstret),
        .mcountinhibit_val(mcountinhibit_val)
    );

endmodule

/* csr_counters.sv */
module csr_counters (
    input  logic                        clk,
    input  logic                        rst_n,
    input  csr_pkg::csr_sel_e           wr_sel,
    input  logic [csr_pkg::XLEN-1:0]    wr_data,
    input  logic                        retire,
    output logic [csr_pkg::CNT_W-1:0]   mcycle,
    output logic [csr_pkg::CNT_W-1:0]   minstret,
    output logic [csr_pkg::XLEN-1:0]    mcountinhibit_val
);

    logic inhibit_cy;
    logic inhibit_ir;

    // half writes win over the increment
    function automatic logic [csr_pkg::CNT_W-1:0] count_next(
        input logic [csr_pkg::CNT_W-1:0] cnt,
        input logic                      inc,
        input logic                      wr_lo,
        input logic                      wr_hi,
        input logic [csr_pkg::XLEN-1:0]  data
    );
        logic [csr_pkg::CNT_W-1:0] nxt;
        nxt = inc ? cnt + 1'b1 : cnt;
        if (wr_lo) begin
            nxt = {cnt[63:32], data};
        end
        if (wr_hi) begin
            nxt = {data, cnt[31:0]};
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle     <= '0;
            minstret   <= '0;
            inhibit_cy <= 1'b0;
            inhibit_ir <= 1'b0;
        end else begin
            mcycle   <= count_next(mcycle, !inhibit_cy,
                                   wr_sel == csr_pkg::SEL_MCYCLE,
                                   wr_sel == csr_pkg::SEL_MCYCLEH, wr_data);
            minstret <= count_next(minstret, retire && !inhibit_ir,
                                   wr_sel == csr_pkg::SEL_MINSTRET,
                                   wr_sel == csr_pkg::SEL_MINSTRETH, wr_data);
            if (wr_sel == csr_pkg::SEL_MCOUNTINHIBIT) begin
                inhibit_cy <= wr_data[csr_pkg::MCOUNTINHIBIT_CY_BIT];
                inhibit_ir <= wr_data[csr_pkg::MCOUNTINHIBIT_IR_BIT];
            end
        end
    end

    // only CY and IR are kept
    always_comb begin
        mcountinhibit_val = '0;
        mcountinhibit_val[csr_pkg::MCOUNTINHIBIT_CY_BIT] = inhibit_cy;
        mcountinhibit_val[csr_pkg::MCOUNTINHIBIT_IR_BIT] = inhibit_ir;
    end

endmodule

/* csr_trap_state.sv */
module csr_trap_state (
    input  logic                        clk,
    input  logic                        rst_n,
    input  csr_pkg::csr_sel_e           wr_sel,
    input  logic [csr_pkg::XLEN-1:0]    wr_data,
    input  logic                        trap_insert,
    input  logic                        trap_is_mret,
    input  logic [csr_pkg::XLEN-1:0]    trap_epc,
    input  logic [csr_pkg::XLEN-1:0]    trap_cause,
    input  logic [csr_pkg::XLEN-1:0]    trap_val,
    input  logic                        timer_irq,
    output csr_pkg::priv_mode_e         priv,
    output logic [csr_pkg::XLEN-1:0]    mstatus_val,
    output logic [csr_pkg::XLEN-1:0]    mtvec,
    output logic [csr_pkg::XLEN-1:0]    mie_val,
    output logic [csr_pkg::XLEN-1:0]    mip_val,
    output logic [csr_pkg::XLEN-1:0]    mscratch,
    output logic [csr_pkg::XLEN-1:0]    mepc,
    output logic [csr_pkg::XLEN-1:0]    mcause,
    output logic [csr_pkg::XLEN-1:0]    mtval,
    output logic                        irq_request
);

    localparam int AB = csr_pkg::MTVEC_ALIGN_BITS;

    logic                mstatus_mie;
    logic                mstatus_mpie;
    csr_pkg::priv_mode_e mstatus_mpp;
    logic                mie_mti;
    logic                mip_mti;

    ///////////////////////////////////////////////////////////////////////
    // state update
    ///////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            priv         <= csr_pkg::PRIV_M;
            mstatus_mie  <= 1'b1;
            mstatus_mpie <= 1'b1;
            mstatus_mpp  <= csr_pkg::PRIV_U;
            mtvec        <= '0;
            mie_mti      <= 1'b0;
            mip_mti      <= 1'b0;
            mscratch     <= '0;
            mepc         <= '0;
            mcause       <= '0;
            mtval        <= '0;
        end else begin
            mip_mti <= timer_irq;

            case (wr_sel)
                csr_pkg::SEL_MSTATUS: begin
                    mstatus_mie  <= wr_data[csr_pkg::MSTATUS_MIE_BIT];
                    mstatus_mpie <= wr_data[csr_pkg::MSTATUS_MPIE_BIT];
                    // only M and U exist, anything else falls back to U
                    if (wr_data[csr_pkg::MSTATUS_MPP_LSB +: 2] == csr_pkg::PRIV_M) begin
                        mstatus_mpp <= csr_pkg::PRIV_M;
                    end else begin
                        mstatus_mpp <= csr_pkg::PRIV_U;
                    end
                end
                csr_pkg::SEL_MTVEC: begin
                    if (wr_data[1:0] == csr_pkg::MTVEC_MODE_VECTORED) begin
                        mtvec <= {wr_data[csr_pkg::XLEN-1:AB], {(AB-2){1'b0}},
                                  csr_pkg::MTVEC_MODE_VECTORED};
                    end else begin
                        mtvec <= {wr_data[csr_pkg::XLEN-1:2], csr_pkg::MTVEC_MODE_DIRECT};
                    end
                end
                csr_pkg::SEL_MIE:      mie_mti  <= wr_data[csr_pkg::MIP_MTI_BIT];
                csr_pkg::SEL_MSCRATCH: mscratch <= wr_data;
                csr_pkg::SEL_MEPC:     mepc     <= {wr_data[csr_pkg::XLEN-1:2], 2'b00};
                csr_pkg::SEL_MCAUSE:   mcause   <= wr_data;
                csr_pkg::SEL_MTVAL:    mtval    <= wr_data;
                default: begin
                end
            endcase

            // trap and mret override a CSR write in the same cycle
            if (trap_insert) begin
                if (trap_is_mret) begin
                    priv         <= mstatus_mpp;
                    mstatus_mie  <= mstatus_mpie;
                    mstatus_mpie <= 1'b1;
                    mstatus_mpp  <= csr_pkg::PRIV_U;
                end else begin
                    priv         <= csr_pkg::PRIV_M;
                    mstatus_mpie <= mstatus_mie;
                    mstatus_mie  <= 1'b0;
                    mstatus_mpp  <= priv;
                    mepc         <= trap_epc;
                    mcause       <= trap_cause;
                    mtval        <= trap_val;
                end
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // register views and interrupt request
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        mstatus_val = '0;
        mstatus_val[csr_pkg::MSTATUS_MIE_BIT]      = mstatus_mie;
        mstatus_val[csr_pkg::MSTATUS_MPIE_BIT]     = mstatus_mpie;
        mstatus_val[csr_pkg::MSTATUS_MPP_LSB +: 2] = mstatus_mpp;
        mie_val = '0;
        mie_val[csr_pkg::MIP_MTI_BIT] = mie_mti;
        mip_val = '0;
        mip_val[csr_pkg::MIP_MTI_BIT] = mip_mti;
    end

    // user mode always takes machine interrupts
    assign irq_request = mip_mti && mie_mti &&
                         (priv != csr_pkg::PRIV_M || mstatus_mie);

endmodule

/* csr_access.sv */
module csr_access (
    input  logic                            rd_en,
    input  logic                            wr_en,
    input  csr_pkg::csr_addr_t              addr,
    input  csr_pkg::priv_mode_e             priv,
    input  logic [csr_pkg::XLEN-1:0]        mstatus_val,
    input  logic [csr_pkg::XLEN-1:0]        mtvec,
    input  logic [csr_pkg::XLEN-1:0]        mie_val,
    input  logic [csr_pkg::XLEN-1:0]        mip_val,
    input  logic [csr_pkg::XLEN-1:0]        mscratch,
    input  logic [csr_pkg::XLEN-1:0]        mepc,
    input  logic [csr_pkg::XLEN-1:0]        mcause,
    input  logic [csr_pkg::XLEN-1:0]        mtval,
    input  logic [csr_pkg::CNT_W-1:0]       mcycle,
    input  logic [csr_pkg::CNT_W-1:0]       minstret,
    input  logic [csr_pkg::XLEN-1:0]        mcountinhibit_val,
    output logic [csr_pkg::XLEN-1:0]        rd_data,
    output logic                            illegal_csr,
    output csr_pkg::csr_sel_e               wr_sel
);

    csr_pkg::csr_sel_e sel;
    logic              needs_m;
    logic              denied;
    logic              writable;

    ///////////////////////////////////////////////////////////////////////
    // address decode
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        // everything but the counter aliases is machine level
        needs_m = 1'b1;
        case (addr)
            csr_pkg::ADDR_CYCLE:         sel = csr_pkg::SEL_CYCLE;
            csr_pkg::ADDR_CYCLEH:        sel = csr_pkg::SEL_CYCLEH;
            csr_pkg::ADDR_INSTRET:       sel = csr_pkg::SEL_INSTRET;
            csr_pkg::ADDR_INSTRETH:      sel = csr_pkg::SEL_INSTRETH;
            csr_pkg::ADDR_MISA:          sel = csr_pkg::SEL_MISA;
            csr_pkg::ADDR_MVENDORID:     sel = csr_pkg::SEL_MVENDORID;
            csr_pkg::ADDR_MARCHID:       sel = csr_pkg::SEL_MARCHID;
            csr_pkg::ADDR_MIMPID:        sel = csr_pkg::SEL_MIMPID;
            csr_pkg::ADDR_MHARTID:       sel = csr_pkg::SEL_MHARTID;
            csr_pkg::ADDR_MSTATUS:       sel = csr_pkg::SEL_MSTATUS;
            csr_pkg::ADDR_MTVEC:         sel = csr_pkg::SEL_MTVEC;
            csr_pkg::ADDR_MIE:           sel = csr_pkg::SEL_MIE;
            csr_pkg::ADDR_MIP:           sel = csr_pkg::SEL_MIP;
            csr_pkg::ADDR_MSCRATCH:      sel = csr_pkg::SEL_MSCRATCH;
            csr_pkg::ADDR_MEPC:          sel = csr_pkg::SEL_MEPC;
            csr_pkg::ADDR_MCAUSE:        sel = csr_pkg::SEL_MCAUSE;
            csr_pkg::ADDR_MTVAL:         sel = csr_pkg::SEL_MTVAL;
            csr_pkg::ADDR_MCYCLE:        sel = csr_pkg::SEL_MCYCLE;
            csr_pkg::ADDR_MCYCLEH:       sel = csr_pkg::SEL_MCYCLEH;
            csr_pkg::ADDR_MINSTRET:      sel = csr_pkg::SEL_MINSTRET;
            csr_pkg::ADDR_MINSTRETH:     sel = csr_pkg::SEL_MINSTRETH;
            csr_pkg::ADDR_MCOUNTINHIBIT: sel = csr_pkg::SEL_MCOUNTINHIBIT;
            default:                     sel = csr_pkg::SEL_NONE;
        endcase
        if (sel == csr_pkg::SEL_CYCLE || sel == csr_pkg::SEL_CYCLEH ||
            sel == csr_pkg::SEL_INSTRET || sel == csr_pkg::SEL_INSTRETH) begin
            needs_m = 1'b0;
        end
    end

    // unimplemented, or machine level from user mode
    assign denied = (sel == csr_pkg::SEL_NONE) ||
                    (needs_m && priv == csr_pkg::PRIV_U);
    assign illegal_csr = (rd_en || wr_en) && denied;

    ///////////////////////////////////////////////////////////////////////
    // read mux
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        case (sel)
            csr_pkg::SEL_CYCLE, csr_pkg::SEL_MCYCLE:       rd_data = mcycle[31:0];
            csr_pkg::SEL_CYCLEH, csr_pkg::SEL_MCYCLEH:     rd_data = mcycle[63:32];
            csr_pkg::SEL_INSTRET, csr_pkg::SEL_MINSTRET:   rd_data = minstret[31:0];
            csr_pkg::SEL_INSTRETH, csr_pkg::SEL_MINSTRETH: rd_data = minstret[63:32];
            csr_pkg::SEL_MISA:          rd_data = csr_pkg::MISA_VALUE;
            csr_pkg::SEL_MIMPID:        rd_data = csr_pkg::MIMPID_VALUE;
            csr_pkg::SEL_MHARTID:       rd_data = csr_pkg::HART_ID;
            csr_pkg::SEL_MSTATUS:       rd_data = mstatus_val;
            csr_pkg::SEL_MTVEC:         rd_data = mtvec;
            csr_pkg::SEL_MIE:           rd_data = mie_val;
            csr_pkg::SEL_MIP:           rd_data = mip_val;
            csr_pkg::SEL_MSCRATCH:      rd_data = mscratch;
            csr_pkg::SEL_MEPC:          rd_data = mepc;
            csr_pkg::SEL_MCAUSE:        rd_data = mcause;
            csr_pkg::SEL_MTVAL:         rd_data = mtval;
            csr_pkg::SEL_MCOUNTINHIBIT: rd_data = mcountinhibit_val;
            // mvendorid and marchid read as zero
            default:                    rd_data = '0;
        endcase
        if (denied) begin
            rd_data = '0;
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // write qualification
    ///////////////////////////////////////////////////////////////////////
    always_comb begin
        case (sel)
            csr_pkg::SEL_MSTATUS, csr_pkg::SEL_MTVEC, csr_pkg::SEL_MIE,
            csr_pkg::SEL_MSCRATCH, csr_pkg::SEL_MEPC, csr_pkg::SEL_MCAUSE,
            csr_pkg::SEL_MTVAL, csr_pkg::SEL_MCYCLE, csr_pkg::SEL_MCYCLEH,
            csr_pkg::SEL_MINSTRET, csr_pkg::SEL_MINSTRETH,
            csr_pkg::SEL_MCOUNTINHIBIT: writable = 1'b1;
            default:                    writable = 1'b0;
        endcase
    end

    assign wr_sel = (wr_en && !denied && writable) ? sel : csr_pkg::SEL_NONE;

endmodule

/* csr_pkg.sv */
package csr_pkg;

    ///////////////////////////////////////////////////////////////////////
    // widths and basic types
    ///////////////////////////////////////////////////////////////////////
    localparam int XLEN  = 32;
    localparam int CNT_W = 64;

    typedef logic [11:0] csr_addr_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_mode_e;

    ///////////////////////////////////////////////////////////////////////
    // CSR addresses
    ///////////////////////////////////////////////////////////////////////
    // user counter aliases
    localparam csr_addr_t ADDR_CYCLE         = 12'hC00;
    localparam csr_addr_t ADDR_INSTRET       = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH        = 12'hC80;
    localparam csr_addr_t ADDR_INSTRETH      = 12'hC82;
    // machine identity
    localparam csr_addr_t ADDR_MVENDORID     = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID       = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID        = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID       = 12'hF14;
    // machine trap setup and handling
    localparam csr_addr_t ADDR_MSTATUS       = 12'h300;
    localparam csr_addr_t ADDR_MISA          = 12'h301;
    localparam csr_addr_t ADDR_MIE           = 12'h304;
    localparam csr_addr_t ADDR_MTVEC         = 12'h305;
    localparam csr_addr_t ADDR_MCOUNTINHIBIT = 12'h320;
    localparam csr_addr_t ADDR_MSCRATCH      = 12'h340;
    localparam csr_addr_t ADDR_MEPC          = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE        = 12'h342;
    localparam csr_addr_t ADDR_MTVAL         = 12'h343;
    localparam csr_addr_t ADDR_MIP           = 12'h344;
    // machine counters
    localparam csr_addr_t ADDR_MCYCLE        = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET      = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH       = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH     = 12'hB82;

    // register select, one per implemented CSR
    typedef enum logic [4:0] {
        SEL_NONE,
        SEL_CYCLE, SEL_CYCLEH, SEL_INSTRET, SEL_INSTRETH,
        SEL_MISA, SEL_MVENDORID, SEL_MARCHID, SEL_MIMPID, SEL_MHARTID,
        SEL_MSTATUS, SEL_MTVEC, SEL_MIE, SEL_MIP,
        SEL_MSCRATCH, SEL_MEPC, SEL_MCAUSE, SEL_MTVAL,
        SEL_MCYCLE, SEL_MCYCLEH, SEL_MINSTRET, SEL_MINSTRETH,
        SEL_MCOUNTINHIBIT
    } csr_sel_e;

    ///////////////////////////////////////////////////////////////////////
    // field positions and constant values
    ///////////////////////////////////////////////////////////////////////
    localparam logic [1:0] MTVEC_MODE_DIRECT   = 2'd0;
    localparam logic [1:0] MTVEC_MODE_VECTORED = 2'd1;
    localparam int MTVEC_ALIGN_BITS = 6;

    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;

    localparam int MIP_MTI_BIT = 7;

    localparam int MCOUNTINHIBIT_CY_BIT = 0;
    localparam int MCOUNTINHIBIT_IR_BIT = 2;

    // MXL = 1 for RV32, no extension bits
    localparam logic [XLEN-1:0] MISA_VALUE   = 32'h4000_0000;
    localparam logic [XLEN-1:0] MIMPID_VALUE = 32'h0000_0001;
    localparam logic [XLEN-1:0] HART_ID      = 32'h0000_0000;

endpackage
